/* hdl/dds_num_pkg.sv */
`default_nettype none

// number formats shared by the datapath blocks
package dds_num_pkg;

   parameter int PHASE_W  = 24;   // phase and frequency word width
   parameter int SAMPLE_W = 16;   // output sample width
   parameter int SLOPE_W  = 12;   // table slope magnitude width

   // peak magnitude of a sample, 2^(SAMPLE_W-1) - 1
   parameter int FULL_SCALE = (2 ** (SAMPLE_W - 1)) - 1;

   typedef logic [PHASE_W-1:0]         phase_t;    // unsigned turn fraction
   typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement cosine

   // one quarter-wave table entry
   typedef struct packed {
      logic [SAMPLE_W-2:0] coarse;   // magnitude at the table point
      logic [SLOPE_W-1:0]  slope;    // drop to the next point, always >= 0
   } table_word_t;

   // record from table to interpolator
   typedef struct packed {
      logic [PHASE_W-3:0] angle;    // folded angle within the quadrant
      table_word_t        word;     // rom word for the upper angle bits
      logic               neg;      // quadrants 1 and 2 are negative
      logic               valid;
   } lookup_t;

endpackage

`default_nettype wire

/* hdl/dds_ctrl_pkg.sv */
`default_nettype none

// command and control types
package dds_ctrl_pkg;

   // command opcodes
   typedef enum logic [2:0] {
      OP_NOP   = 3'd0,
      OP_FREQ  = 3'd1,   // arg -> frequency word
      OP_PHASE = 3'd2,   // arg -> phase
      OP_RUN   = 3'd3,   // free running
      OP_HALT  = 3'd4,   // stop stepping
      OP_BURST = 3'd5    // arg samples then stop
   } dds_op_t;

   typedef struct packed {
      dds_op_t     op;
      logic [31:0] arg;
   } dds_cmd_t;

   // sequencer states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_RUN   = 2'd1,
      ST_BURST = 2'd2
   } seq_state_t;

endpackage

`default_nettype wire

/* hdl/phase_accum.sv */
`timescale 1ns/1ps
`default_nettype none

// frequency word plus phase counter
// phase moves one cycle after a step or a load
module phase_accum
   import dds_num_pkg::*;
(
   input  logic   c,
   input  logic   arst_n,
   input  logic   freq_load,    // take load_value as frequency word
   input  logic   phase_load,   // take load_value as phase
   input  phase_t load_value,
   input  logic   step,         // advance by one frequency word
   output phase_t phase
);

   phase_t freq;   // phase increment per step
   phase_t phase_nx;

   // natural wrap, PHASE_W bits modulo 2^PHASE_W
   assign phase_nx = phase + freq;

   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) begin
         freq <= '0;
      end else if (freq_load) begin
         freq <= load_value;   // a step in the same cycle still uses the old word
      end
   end

   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) begin
         phase <= '0;
      end else begin
         if (phase_load) begin
            phase <= load_value;   // load wins over step
         end else if (step) begin
            phase <= phase_nx;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/dds_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

// command decoder and step generator
// commands are taken in any state, last command wins
module dds_sequencer
   import dds_num_pkg::*, dds_ctrl_pkg::*;
(
   input  logic     c,
   input  logic     arst_n,
   input  logic     cmd_valid,    // single cycle strobe
   input  dds_cmd_t cmd,
   output logic     freq_load,
   output logic     phase_load,
   output phase_t   load_value,
   output logic     step,         // one phase step per high cycle
   output logic     busy
);

   seq_state_t  state, state_nx;
   logic [31:0] burst_cnt;   // steps still to issue in ST_BURST
   logic [31:0] cnt_nx;

   always_comb begin
      state_nx = state;
      cnt_nx   = burst_cnt;
      // a burst cycle issues one step
      if (state == ST_BURST) begin
         cnt_nx = burst_cnt - 32'd1;
         if (burst_cnt == 32'd1) begin
            state_nx = ST_IDLE;   // last step goes out this cycle
         end
      end
      if (cmd_valid) begin
         case (cmd.op)
            OP_RUN:  state_nx = ST_RUN;
            OP_HALT: state_nx = ST_IDLE;
            OP_BURST: begin
               cnt_nx   = cmd.arg;
               state_nx = (cmd.arg == 32'd0) ? ST_IDLE : ST_BURST;   // empty burst, nothing to do
            end
            default: ;   // loads and nop leave the state alone
         endcase
      end
   end

   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) begin
         state      <= ST_IDLE;
         burst_cnt  <= '0;
         step       <= 1'b0;
         freq_load  <= 1'b0;
         phase_load <= 1'b0;
      end else begin
         state      <= state_nx;
         burst_cnt  <= cnt_nx;
         step       <= (state_nx != ST_IDLE);   // aligned with the state register
         freq_load  <= cmd_valid && (cmd.op == OP_FREQ);
         phase_load <= cmd_valid && (cmd.op == OP_PHASE);
      end
   end

   // argument rides along with the load strobes
   always_ff @(posedge c) begin
      if (cmd_valid) begin
         load_value <= cmd.arg[PHASE_W-1:0];
      end
   end

   // busy drops together with the last burst step
   assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

/* hdl/cosine_table.sv */
`timescale 1ns/1ps
`default_nettype none

// quadrant fold and quarter-wave rom, 2 cycles
module cosine_table
   import dds_num_pkg::*;
#(
   parameter int TABLE_BITS = 10   // rom address bits per quarter wave
)(
   input  logic    c,
   input  logic    arst_n,
   input  phase_t  phase,
   input  logic    phase_valid,
   output lookup_t lookup
);

   localparam int  DEPTH   = 2 ** TABLE_BITS;
   localparam int  ANGLE_W = PHASE_W - 2;
   localparam real HALF_PI = 1.5707963267948966;

   // entry i holds cos at i/DEPTH of a quarter turn and the drop to i+1
   function automatic table_word_t calc_word(input int idx);
      real         step_rad;
      int          c0;
      int          c1;
      table_word_t tw;
      step_rad  = HALF_PI / real'(DEPTH);
      c0        = int'($floor(real'(FULL_SCALE) * $cos(step_rad * real'(idx)) + 0.5));
      c1        = int'($floor(real'(FULL_SCALE) * $cos(step_rad * real'(idx + 1)) + 0.5));
      tw.coarse = (SAMPLE_W - 1)'(c0);
      tw.slope  = SLOPE_W'(c0 - c1);   // last entry drops to zero at a quarter turn
      return tw;
   endfunction

   table_word_t rom [DEPTH];

   for (genvar i = 0; i < DEPTH; i++) begin : g_rom
      localparam table_word_t ROM_WORD = calc_word(i);
      assign rom[i] = ROM_WORD;
   end

   logic [ANGLE_W-1:0] angle_in, angle_1, angle_2;
   logic               neg_1, neg_2;
   logic               valid_1, valid_2;
   table_word_t        word_2;

   // odd quadrants run backwards through the table
   assign angle_in = phase[PHASE_W-2] ? ~phase[ANGLE_W-1:0] : phase[ANGLE_W-1:0];

   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) begin
         valid_1 <= 1'b0;
         valid_2 <= 1'b0;
      end else begin
         valid_1 <= phase_valid;
         valid_2 <= valid_1;
      end
   end

   always_ff @(posedge c) begin
      angle_1 <= angle_in;                                  // folded address stage
      neg_1   <= phase[PHASE_W-1] ^ phase[PHASE_W-2];       // quadrants 1, 2
      angle_2 <= angle_1;
      neg_2   <= neg_1;
      word_2  <= rom[angle_1[ANGLE_W-1 -: TABLE_BITS]];   // registered rom read
   end

   assign lookup = '{angle: angle_2, word: word_2, neg: neg_2, valid: valid_2};

endmodule

`default_nettype wire

/* hdl/cosine_interp.sv */
`timescale 1ns/1ps
`default_nettype none

// linear interpolation between table points, 4 cycles
//   sample = +/- (coarse - round(frac * slope / 2^FRAC_W))
module cosine_interp
   import dds_num_pkg::*;
#(
   parameter int TABLE_BITS = 10
)(
   input  logic    c,
   input  logic    arst_n,
   input  lookup_t lookup,
   output logic    sample_valid,
   output sample_t sample
);

   localparam int FRAC_W = PHASE_W - 2 - TABLE_BITS;   // angle bits below the rom address
   localparam int PROD_W = FRAC_W + SLOPE_W;
   localparam int MAG_W  = SAMPLE_W - 1;
   localparam logic [PROD_W:0] ROUND = (PROD_W + 1)'(1) << (FRAC_W - 1);

   logic [3:0]         vld_sr;   // valid per stage
   logic [2:0]         neg_sr;   // sign, used by stage 4

   // stage 1, split
   logic [FRAC_W-1:0]  frac_1;
   logic [SLOPE_W-1:0] slope_1;
   logic [MAG_W-1:0]   coarse_1;
   // stage 2, multiply
   logic [PROD_W-1:0]  prod_2;
   logic [MAG_W-1:0]   coarse_2;
   // stage 3, subtract
   logic [PROD_W:0]    prod_rnd;
   logic [SLOPE_W:0]   drop;
   logic [MAG_W-1:0]   mag_3;
   logic signed [SAMPLE_W-1:0] mag_s;

   assign prod_rnd = {1'b0, prod_2} + ROUND;   // round to nearest before the shift
   assign drop     = prod_rnd[PROD_W:FRAC_W];    // never exceeds slope, no underflow below
   assign mag_s    = {1'b0, mag_3};

   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) begin
         vld_sr <= '0;
      end else begin
         vld_sr <= {vld_sr[2:0], lookup.valid};
      end
   end

   always_ff @(posedge c) begin
      neg_sr   <= {neg_sr[1:0], lookup.neg};
      frac_1   <= lookup.angle[FRAC_W-1:0];
      slope_1  <= lookup.word.slope;
      coarse_1 <= lookup.word.coarse;
      prod_2   <= frac_1 * slope_1;   // unsigned, full width
      coarse_2 <= coarse_1;
      mag_3    <= coarse_2 - MAG_W'(drop);
      sample   <= neg_sr[2] ? -mag_s : mag_s;   // sign restore
   end

   assign sample_valid = vld_sr[3];

endmodule

`default_nettype wire

/* hdl/dds_top.sv */
`timescale 1ns/1ps
`default_nettype none

// dds top, step to sample_valid is 7 cycles
//   1 phase capture, 2 table, 4 interpolator
module dds_top
   import dds_num_pkg::*, dds_ctrl_pkg::*;
#(
   parameter int TABLE_BITS = 10
)(
   input  logic     c,
   input  logic     arst_n,
   input  logic     cmd_valid,
   input  dds_cmd_t cmd,
   output logic     busy,
   output logic     sample_valid,
   output sample_t  sample
);

   logic    freq_load;
   logic    phase_load;
   phase_t  load_value;
   logic    step;
   logic    step_q;    // step, one cycle late
   phase_t  phase;
   phase_t  phase_q;   // phase as it was when stepped
   lookup_t lookup;

   dds_sequencer seq_i (
      .c(c), .arst_n(arst_n),
      .cmd_valid(cmd_valid), .cmd(cmd),
      .freq_load(freq_load), .phase_load(phase_load), .load_value(load_value),
      .step(step), .busy(busy)
   );

   phase_accum accum_i (
      .c(c), .arst_n(arst_n),
      .freq_load(freq_load), .phase_load(phase_load), .load_value(load_value),
      .step(step), .phase(phase)
   );

   // capture the pre-step phase, the counter moves on at the same edge
   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) step_q <= 1'b0;
      else         step_q <= step;
   end

   always_ff @(posedge c) begin
      phase_q <= phase;
   end

   cosine_table #(.TABLE_BITS(TABLE_BITS)) table_i (
      .c(c), .arst_n(arst_n),
      .phase(phase_q), .phase_valid(step_q),
      .lookup(lookup)
   );

   cosine_interp #(.TABLE_BITS(TABLE_BITS)) interp_i (
      .c(c), .arst_n(arst_n),
      .lookup(lookup),
      .sample_valid(sample_valid), .sample(sample)
   );

endmodule

`default_nettype wire

/* bench/dds_properties.sv */
`timescale 1ns/1ps
`default_nettype none

// sequencer and output strobe checks bound into dds_top
module dds_properties
   import dds_ctrl_pkg::*;
(
   input logic        c,
   input logic        arst_n,
   input logic        busy,
   input logic        step,
   input logic        sample_valid,
   input seq_state_t  state,       // sequencer state
   input logic [31:0] burst_cnt    // steps left in a burst
);

   logic [2:0] since_rst;   // cycles since reset release up to 7

   always_ff @(posedge c or negedge arst_n) begin
      if (!arst_n) since_rst <= '0;
      else if (since_rst != 3'd7) since_rst <= since_rst + 3'd1;
   end

   // every step comes out as a sample 7 cycles later
   a_step_to_sample : assert property (@(posedge c) disable iff (!arst_n)
      step |-> ##7 sample_valid) else $error("no sample 7 cycles after a step");

   // an idle cycle leaves a hole in the output 7 cycles later
   a_idle_no_sample : assert property (@(posedge c) disable iff (!arst_n)
      !busy |-> ##7 !sample_valid) else $error("sample without a step 7 cycles earlier");

   // pipeline holds nothing right after reset
   a_quiet_after_reset : assert property (@(posedge c) disable iff (!arst_n)
      (since_rst != 3'd7) |-> !sample_valid) else $error("sample_valid early after reset");

   // zero in ST_BURST would wrap and never end
   a_burst_cnt_live : assert property (@(posedge c) disable iff (!arst_n)
      (state == ST_BURST) |-> (burst_cnt != 32'd0)) else $error("burst count zero in ST_BURST");

endmodule

bind dds_top dds_properties props_i (
   .c(c), .arst_n(arst_n),
   .busy(busy), .step(step), .sample_valid(sample_valid),
   .state(seq_i.state), .burst_cnt(seq_i.burst_cnt)
);

`default_nettype wire

/* bench/dds_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// directed testbench for dds_top
// a monitor queues every sample and the tests queue the phases they expect
module dds_tb
   import dds_num_pkg::*, dds_ctrl_pkg::*;
;

   localparam int  TABLE_BITS = 10;
   localparam int  CLK_PERIOD = 10;            // ns
   localparam int  TOL        = 3;             // lsb tolerance on samples
   localparam int  RUN_CYCLES = 40;            // free running time in test 4
   localparam int  NUM_TESTS  = 5;
   localparam int  TOTAL_SAMPLES = 4 * 4 + 64 + RUN_CYCLES + 16 + 10 * 32;
   localparam int  WATCHDOG_CYCLES = TOTAL_SAMPLES + 100 * NUM_TESTS;
   localparam real TWO_PI = 6.283185307179586;

   logic     c;
   logic     arst_n;
   logic     cmd_valid;
   dds_cmd_t cmd;
   logic     busy;
   logic     sample_valid;
   sample_t  sample;

   int      errors = 0;
   int      cyc = 0;          // rising edges since start
   int      first_step = 0;   // cycle of the first step of the last burst
   int      seed = 32'hdacd_dcea;
   phase_t  phase_model;      // phase the next step will emit
   phase_t  freq_model;
   sample_t got_q[$];         // samples seen by the monitor
   int      cyc_q[$];         // and the cycle each one came in
   phase_t  exp_q[$];         // phases the samples should carry

   dds_top #(.TABLE_BITS(TABLE_BITS)) dds_top_i (
      .c(c), .arst_n(arst_n),
      .cmd_valid(cmd_valid), .cmd(cmd),
      .busy(busy), .sample_valid(sample_valid), .sample(sample)
   );

   initial begin
      c = 1'b0;
      forever #(CLK_PERIOD / 2) c = ~c;
   end

   always @(posedge c) cyc <= cyc + 1;

   // outputs change on the rising edge so they are read on the falling one
   always @(negedge c) begin
      if (sample_valid) begin
         got_q.push_back(sample);
         cyc_q.push_back(cyc);
      end
   end

   // round(FULL_SCALE * cos(2 pi phase / 2^PHASE_W))
   function automatic sample_t cos_ref(phase_t ph);
      real ang;
      ang = TWO_PI * real'(ph) / (2.0 ** PHASE_W);
      return sample_t'($rtoi($floor(real'(FULL_SCALE) * $cos(ang) + 0.5)));
   endfunction

   task automatic check_sample(string name, sample_t got, sample_t exp, int tol);
      int diff;
      diff = int'(got) - int'(exp);
      if (diff > tol || diff < -tol) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_count(string name, int got, int exp);
      if (got != exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_level(string name, logic got, logic exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // driven on the falling edge and held for one cycle
   task automatic send_cmd(dds_op_t op, logic [31:0] arg);
      cmd_valid = 1'b1;
      cmd       = '{op: op, arg: arg};
      @(negedge c);
      cmd_valid = 1'b0;
      cmd       = '{op: OP_NOP, arg: 32'd0};
   endtask

   task automatic set_freq(phase_t f);
      send_cmd(OP_FREQ, 32'(f));
      freq_model = f;
   endtask

   task automatic set_phase(phase_t p);
      send_cmd(OP_PHASE, 32'(p));
      phase_model = p;
   endtask

   // queue the phases of n steps as P, P+F and so on
   task automatic expect_steps(int n);
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(phase_model);
         phase_model = phase_model + freq_model;   // wraps mod 2^PHASE_W
      end
   endtask

   // burst of n that counts steps until busy drops
   task automatic run_burst(int n);
      int steps;
      int guard;
      steps = 0;
      guard = 0;
      send_cmd(OP_BURST, n);
      while (busy && guard < n + 10) begin
         if (dds_top_i.step && steps == 0) first_step = cyc;
         if (dds_top_i.step) steps++;
         check_level("step", dds_top_i.step, 1'b1);   // one step in every busy cycle
         @(negedge c);
         guard++;
      end
      if (busy) begin
         errors++;
         $display("burst of %0d still busy after %0d cycles", n, guard);
      end
      check_level("step", dds_top_i.step, 1'b0);
      check_count("burst steps", steps, n);
      expect_steps(n);
   endtask

   // done once busy and sample_valid stay low longer than the pipeline
   task automatic wait_idle();
      int quiet;
      int guard;
      quiet = 0;
      guard = 0;
      while (quiet < 9 && guard < 200) begin
         @(negedge c);
         guard++;
         if (busy || sample_valid) quiet = 0;
         else quiet++;
      end
      if (quiet < 9) begin
         errors++;
         $display("pipeline did not go quiet within 200 cycles");
      end
   endtask

   task automatic check_samples();
      int n;
      check_count("sample count", got_q.size(), exp_q.size());
      n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      for (int i = 0; i < n; i++) begin
         check_sample($sformatf("sample[%0d]", i), got_q[i], cos_ref(exp_q[i]), TOL);
      end
      got_q.delete();
      cyc_q.delete();
      exp_q.delete();
   endtask

   task automatic test_reset_quiet();
      repeat (20) begin
         check_level("busy", busy, 1'b0);
         check_level("sample_valid", sample_valid, 1'b0);
         @(negedge c);
      end
   endtask

   // one short burst per quadrant with frequency 0 so all four repeat
   task automatic test_quadrants();
      phase_t offs[4] = '{24'h000010, 24'h000123, 24'h0000ff, 24'h000040};
      set_freq('0);
      for (int q = 0; q < 4; q++) begin
         set_phase(phase_t'(q << (PHASE_W - 2)) + offs[q]);
         run_burst(4);
         wait_idle();
         check_samples();
      end
   endtask

   task automatic test_burst_latency();
      int lat;
      set_freq(24'h004d2f);
      set_phase(24'h123456);
      run_burst(64);
      wait_idle();
      lat = (cyc_q.size() > 0) ? cyc_q[0] - first_step : -1;
      check_count("first sample latency", lat, 7);
      check_samples();
   endtask

   // burst must pick up the phase where the run stopped
   task automatic test_run_halt();
      int run_n;
      set_freq(24'h012345);
      set_phase(24'h300000);
      send_cmd(OP_RUN, 32'd0);
      repeat (RUN_CYCLES) @(negedge c);
      send_cmd(OP_HALT, 32'd0);
      wait_idle();
      run_n = got_q.size();
      if (run_n == 0) begin
         errors++;
         $display("no samples came out while running");
      end
      expect_steps(run_n);
      run_burst(16);
      wait_idle();
      check_samples();
   endtask

   task automatic test_random_bursts();
      for (int b = 0; b < 10; b++) begin
         set_freq(phase_t'($random(seed)));
         set_phase(phase_t'($random(seed)));
         run_burst(32);
         wait_idle();
         check_samples();
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog: run did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      arst_n      = 1'b0;
      cmd_valid   = 1'b0;
      cmd         = '{op: OP_NOP, arg: 32'd0};
      phase_model = '0;
      freq_model  = '0;
      repeat (3) @(posedge c);
      @(negedge c);
      arst_n = 1'b1;
      test_reset_quiet();
      test_quadrants();
      test_burst_latency();
      test_run_halt();
      test_random_bursts();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* dds.f */
hdl/dds_num_pkg.sv
hdl/dds_ctrl_pkg.sv
hdl/phase_accum.sv
hdl/dds_sequencer.sv
hdl/cosine_table.sv
hdl/cosine_interp.sv
hdl/dds_top.sv
bench/dds_properties.sv
bench/dds_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dds testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dds_tb \
   -f dds.f --Mdir obj_dir -o dds_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output="$(./obj_dir/dds_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qF '*** PASSED ***' <<< "$output"; then
   exit 0
fi
exit 1
